// File: include/sort_regs.svh
// ~~~~~~~~~~~~~~~~~~~~
// Sort engine register map
// APB byte offsets and field positions
// ~~~~~~~~~~~~~~~~~~~~

`ifndef SORT_REGS_SVH
`define SORT_REGS_SVH

`define REG_CTRL         (8'h00)
`define REG_COUNT        (8'h04)
`define REG_LANE_BASE    (8'h40)   // Lane i at base + 4*i
`define REG_RESULT_BASE  (8'h80)   // Sorted position i at base + 4*i

`define CTRL_START_BIT   0
`define COUNT_MSB        7
`define KEY_MSB          15
`define TAG_LSB          16
`define TAG_MSB          23

`endif

// File: hdl/sort_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Sort engine package
// APB bus types and default engine sizes
// ~~~~~~~~~~~~~~~~~~~~

package sort_pkg;

    typedef logic [7:0]  addr_t;      // APB byte address
    typedef logic [31:0] apb_data_t;

    // Requester side of one APB slave port
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        addr_t     paddr;
        apb_data_t pwdata;
    } apb_req_t;

    // Completer side
    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    // Lane count must be a power of two, 16 at most
    localparam int DEFAULT_LANES  = 8;
    localparam int DEFAULT_DATA_W = 16;  // Key bits, 16 at most

endpackage

// File: hdl/apb_lane_loader.sv
// ~~~~~~~~~~~~~~~~~~~~
// APB lane loader
// Holds the lane keys written over APB and turns a start
// write on the control register into a launch pulse
// ~~~~~~~~~~~~~~~~~~~~

`include "sort_regs.svh"

module apb_lane_loader #(
    parameter int LANES  = sort_pkg::DEFAULT_LANES,
    parameter int DATA_W = sort_pkg::DEFAULT_DATA_W,
    localparam int TAG_W = $clog2(LANES)
) (
    input  logic                           xif,
    input  logic                           rst_n,
    input  sort_pkg::apb_req_t             apb_req,
    output logic                           wr_err,
    output logic                           launch_valid,
    output logic [LANES-1:0][DATA_W-1:0]   launch_keys
);

    import sort_pkg::*;

    typedef logic [DATA_W-1:0] key_t;
    typedef logic [TAG_W-1:0]  lane_idx_t;

    key_t [LANES-1:0] lane_q;
    addr_t            lane_off;
    lane_idx_t        lane_idx;
    logic             access_wr;
    logic             is_ctrl;
    logic             is_lane;
    logic             start;

    // Write access phase only
    assign access_wr = apb_req.psel & apb_req.penable & apb_req.pwrite;

    assign lane_off = apb_req.paddr - `REG_LANE_BASE;
    assign lane_idx = lane_off[TAG_W+1:2];

    assign is_ctrl = (apb_req.paddr == `REG_CTRL);
    assign is_lane = (apb_req.paddr >= `REG_LANE_BASE) &&
                     (lane_off < addr_t'(4 * LANES)) &&
                     (lane_off[1:0] == 2'b00);

    assign start  = access_wr & is_ctrl & apb_req.pwdata[`CTRL_START_BIT];
    assign wr_err = access_wr & ~(is_ctrl | is_lane);

    // Lane register file
    always_ff @(posedge xif or negedge rst_n) begin
        if (!rst_n) begin
            lane_q <= '0;
        end else if (access_wr && is_lane) begin
            for (int i = 0; i < LANES; i++) begin
                if (lane_idx == lane_idx_t'(i)) begin
                    lane_q[i] <= apb_req.pwdata[DATA_W-1:0];
                end
            end
        end
    end

    // Launch one cycle after the start write
    always_ff @(posedge xif or negedge rst_n) begin
        if (!rst_n) begin
            launch_valid <= 1'b0;
        end else begin
            launch_valid <= start;
        end
    end

    // No lane write can share a cycle with the start write,
    // so the live register file is what gets launched
    assign launch_keys = lane_q;

    // Start writes need a setup cycle in between
    ast_launch_single : assert property (
        @(posedge xif) disable iff (!rst_n)
        launch_valid |=> !launch_valid
    );

endmodule

// File: hdl/bitonic_sorter.sv
// ~~~~~~~~~~~~~~~~~~~~
// Bitonic sorter
// Registered Batcher network, one vector per cycle,
// origin tags and a valid bit travel with the keys
// ~~~~~~~~~~~~~~~~~~~~

module bitonic_sorter #(
    parameter int LANES  = 8,
    parameter int DATA_W = 16,
    localparam int TAG_W  = $clog2(LANES),
    localparam int STAGES = (TAG_W * (TAG_W + 1)) / 2
) (
    input  logic                          xif,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  logic [LANES-1:0][DATA_W-1:0]  in_keys,
    output logic                          out_valid,
    output logic [LANES-1:0][DATA_W-1:0]  out_keys,
    output logic [LANES-1:0][TAG_W-1:0]   out_tags
);

    typedef logic [DATA_W-1:0] key_t;
    typedef logic [TAG_W-1:0]  tag_t;

    key_t key_d [1:STAGES][LANES];
    tag_t tag_d [1:STAGES][LANES];
    key_t key_q [1:STAGES][LANES];
    tag_t tag_q [1:STAGES][LANES];

    logic [STAGES:1] vld_q;
    logic            sorted_ok;

    for (genvar p = 1; p <= TAG_W; p++) begin : g_merge
        localparam bit LAST = (p == TAG_W);
        for (genvar q = p; q >= 1; q--) begin : g_step
            localparam int ST   = ((p - 1) * p) / 2 + (p - q) + 1;
            localparam int DIST = 1 << (q - 1);
            for (genvar i = 0; i < LANES; i++) begin : g_lane
                if ((i ^ DIST) > i) begin : g_pair
                    localparam int  J   = i ^ DIST;
                    localparam bit  ASC = LAST || ((i & (1 << p)) == 0);
                    key_t a_key, b_key, lo_key, hi_key;
                    tag_t a_tag, b_tag, lo_tag, hi_tag;
                    logic swap;

                    if (ST == 1) begin : g_src_in
                        assign a_key = in_keys[i];
                        assign b_key = in_keys[J];
                        assign a_tag = tag_t'(i);    // Origin lane
                        assign b_tag = tag_t'(J);
                    end else begin : g_src_pipe
                        assign a_key = key_q[ST-1][i];
                        assign b_key = key_q[ST-1][J];
                        assign a_tag = tag_q[ST-1][i];
                        assign b_tag = tag_q[ST-1][J];
                    end

                    // Ascending pair first
                    assign swap   = (b_key < a_key);
                    assign lo_key = swap ? b_key : a_key;
                    assign hi_key = swap ? a_key : b_key;
                    assign lo_tag = swap ? b_tag : a_tag;
                    assign hi_tag = swap ? a_tag : b_tag;

                    // Merge direction from the lane bit
                    assign key_d[ST][i] = ASC ? lo_key : hi_key;
                    assign key_d[ST][J] = ASC ? hi_key : lo_key;
                    assign tag_d[ST][i] = ASC ? lo_tag : hi_tag;
                    assign tag_d[ST][J] = ASC ? hi_tag : lo_tag;
                end
            end
        end
    end

    always_ff @(posedge xif) begin
        key_q <= key_d;
        tag_q <= tag_d;
    end

    always_ff @(posedge xif or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q[1] <= in_valid;
            for (int s = 2; s <= STAGES; s++) begin
                vld_q[s] <= vld_q[s-1];
            end
        end
    end

    assign out_valid = vld_q[STAGES];

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            out_keys[i] = key_q[STAGES][i];
            out_tags[i] = tag_q[STAGES][i];
        end
    end

    always_comb begin
        sorted_ok = 1'b1;
        for (int i = 1; i < LANES; i++) begin
            if (out_keys[i] < out_keys[i-1]) begin
                sorted_ok = 1'b0;
            end
        end
    end

    // Whole network must deliver ascending order
    ast_out_sorted : assert property (
        @(posedge xif) disable iff (!rst_n)
        out_valid |-> sorted_ok
    );

endmodule

// File: hdl/sort_result_store.sv
// ~~~~~~~~~~~~~~~~~~~~
// Sort result store
// Keeps the newest sorted vector with its tags,
// counts completions and answers APB reads
// ~~~~~~~~~~~~~~~~~~~~

`include "sort_regs.svh"

module sort_result_store #(
    parameter int LANES  = sort_pkg::DEFAULT_LANES,
    parameter int DATA_W = sort_pkg::DEFAULT_DATA_W,
    localparam int TAG_W = $clog2(LANES)
) (
    input  logic                          xif,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  logic [LANES-1:0][DATA_W-1:0]  in_keys,
    input  logic [LANES-1:0][TAG_W-1:0]   in_tags,
    input  sort_pkg::apb_req_t            apb_req,
    output sort_pkg::apb_data_t           prdata,
    output logic                          rd_err
);

    import sort_pkg::*;

    typedef logic [DATA_W-1:0]     key_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [`COUNT_MSB:0]   count_t;

    key_t [LANES-1:0] res_key_q;
    tag_t [LANES-1:0] res_tag_q;
    count_t           count_q;
    addr_t            res_off;
    tag_t             res_idx;
    logic             access_rd;
    logic             is_count;
    logic             is_result;

    // Newer results overwrite older ones
    always_ff @(posedge xif or negedge rst_n) begin
        if (!rst_n) begin
            res_key_q <= '0;
            res_tag_q <= '0;
            count_q   <= '0;
        end else if (in_valid) begin
            res_key_q <= in_keys;
            res_tag_q <= in_tags;
            count_q   <= count_q + 1'b1;   // Wraps at 256
        end
    end

    assign access_rd = apb_req.psel & apb_req.penable & ~apb_req.pwrite;

    assign res_off = apb_req.paddr - `REG_RESULT_BASE;
    assign res_idx = res_off[TAG_W+1:2];

    assign is_count  = (apb_req.paddr == `REG_COUNT);
    assign is_result = (apb_req.paddr >= `REG_RESULT_BASE) &&
                       (res_off < addr_t'(4 * LANES)) &&
                       (res_off[1:0] == 2'b00);

    assign rd_err = access_rd & ~(is_count | is_result);

    always_comb begin
        prdata = '0;
        if (access_rd && is_count) begin
            prdata = apb_data_t'(count_q);
        end else if (access_rd && is_result) begin
            // Key low, origin tag at TAG_LSB
            prdata = apb_data_t'(res_key_q[res_idx]) |
                     (apb_data_t'(res_tag_q[res_idx]) << `TAG_LSB);
        end
    end

    // Count moves only on a completed sort
    ast_count_on_valid : assert property (
        @(posedge xif) disable iff (!rst_n)
        (count_q != $past(count_q)) |-> $past(in_valid)
    );

endmodule

// File: hdl/sort_engine.sv
// ~~~~~~~~~~~~~~~~~~~~
// Sort engine top
// APB lane loader, bitonic sorter and result store
// in a three stage pipeline behind one APB slave port
// ~~~~~~~~~~~~~~~~~~~~

module sort_engine #(
    parameter int LANES  = sort_pkg::DEFAULT_LANES,
    parameter int DATA_W = sort_pkg::DEFAULT_DATA_W
) (
    input  logic               xif,
    input  logic               rst_n,
    input  sort_pkg::apb_req_t apb_req,
    output sort_pkg::apb_rsp_t apb_rsp
);

    import sort_pkg::*;

    localparam int TAG_W = $clog2(LANES);

    logic                          launch_valid;
    logic [LANES-1:0][DATA_W-1:0]  launch_keys;
    logic                          sort_valid;
    logic [LANES-1:0][DATA_W-1:0]  sort_keys;
    logic [LANES-1:0][TAG_W-1:0]   sort_tags;
    apb_data_t                     rd_data;
    logic                          wr_err;
    logic                          rd_err;

    apb_lane_loader #(.LANES(LANES), .DATA_W(DATA_W)) loader_i (
        .xif          (xif),
        .rst_n        (rst_n),
        .apb_req      (apb_req),
        .wr_err       (wr_err),
        .launch_valid (launch_valid),
        .launch_keys  (launch_keys)
    );

    bitonic_sorter #(.LANES(LANES), .DATA_W(DATA_W)) sorter_i (
        .xif       (xif),
        .rst_n     (rst_n),
        .in_valid  (launch_valid),
        .in_keys   (launch_keys),
        .out_valid (sort_valid),
        .out_keys  (sort_keys),
        .out_tags  (sort_tags)
    );

    sort_result_store #(.LANES(LANES), .DATA_W(DATA_W)) store_i (
        .xif      (xif),
        .rst_n    (rst_n),
        .in_valid (sort_valid),
        .in_keys  (sort_keys),
        .in_tags  (sort_tags),
        .apb_req  (apb_req),
        .prdata   (rd_data),
        .rd_err   (rd_err)
    );

    // No wait states
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.prdata  = rd_data;
    assign apb_rsp.pslverr = wr_err | rd_err;

endmodule

// File: verification/sort_engine_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// Sort engine testbench
// APB stimulus, reference sort checks and bus assertions
// ~~~~~~~~~~~~~~~~~~~~

`include "sort_regs.svh"

module sort_engine_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import sort_pkg::*;

    localparam int LANES      = 8;
    localparam int DATA_W     = 16;
    localparam int TAG_W      = $clog2(LANES);
    localparam int STAGES     = (TAG_W * (TAG_W + 1)) / 2;
    localparam int CLK_PERIOD = 10;
    localparam int NUM_TESTS  = 6;
    localparam int SEED       = 56535;
    localparam int MAX_POLLS  = 40;

    typedef logic [DATA_W-1:0] key_t;

    logic      xif;
    logic      rst_n;
    apb_req_t  apb_req;
    apb_rsp_t  apb_rsp;

    key_t      lane_model [LANES];   // Last key written per lane
    apb_data_t rd_word;
    logic      bus_err;
    logic [7:0] sorts_done;          // Expected completion count

    sort_engine #(.LANES(LANES), .DATA_W(DATA_W)) sort_engine_i (
        .xif     (xif),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    always #(CLK_PERIOD / 2) xif = ~xif;

    task automatic stop_with_failure();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic show_mismatch(input string name, input apb_data_t expected,
                                 input apb_data_t actual);
        $display("error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
        stop_with_failure();
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        stop_with_failure();
    endtask

    // Register map decode for both bus directions
    function automatic logic slverr_expected(input apb_req_t req);
        int  a;
        logic in_lane;
        logic in_result;
        a = int'(req.paddr);
        in_lane   = (a >= `REG_LANE_BASE) && (a < `REG_LANE_BASE + 4 * LANES) &&
                    (a % 4 == 0);
        in_result = (a >= `REG_RESULT_BASE) && (a < `REG_RESULT_BASE + 4 * LANES) &&
                    (a % 4 == 0);
        if (!(req.psel && req.penable)) return 1'b0;
        if (req.pwrite) return !((a == `REG_CTRL) || in_lane);
        return !((a == `REG_COUNT) || in_result);
    endfunction

    // One setup and one access cycle, stepping 1 ns after each rising edge
    task automatic write_reg(input addr_t addr, input apb_data_t data);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(posedge xif);
        #1;
        apb_req.penable = 1'b1;
        @(negedge xif);
        bus_err = apb_rsp.pslverr;
        @(posedge xif);
        #1;
        apb_req = '0;
    endtask

    task automatic read_reg(input addr_t addr);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
        @(posedge xif);
        #1;
        apb_req.penable = 1'b1;
        @(negedge xif);   // Mid access cycle
        rd_word = apb_rsp.prdata;
        bus_err = apb_rsp.pslverr;
        @(posedge xif);
        #1;
        apb_req = '0;
    endtask

    task automatic write_lane(input int lane, input key_t key);
        write_reg(addr_t'(`REG_LANE_BASE + 4 * lane), apb_data_t'(key));
        lane_model[lane] = key;
    endtask

    task automatic launch_sort();
        write_reg(`REG_CTRL, apb_data_t'(1) << `CTRL_START_BIT);
    endtask

    task automatic wait_for_count(input logic [7:0] target);
        int polls;
        polls = 0;
        read_reg(`REG_COUNT);
        while (rd_word[`COUNT_MSB:0] != target) begin
            polls++;
            if (polls > MAX_POLLS) begin
                report_problem("completion count never reached the expected value");
            end
            read_reg(`REG_COUNT);
        end
    endtask

    // Compare every sorted position with a reference sort of the lanes
    task automatic check_results();
        key_t             exp_keys [LANES];
        key_t             tmp;
        key_t             key;
        key_t             prev_key;
        logic [7:0]       tag;
        logic [LANES-1:0] seen;
        exp_keys = lane_model;
        for (int i = 1; i < LANES; i++) begin
            for (int j = i; j > 0 && exp_keys[j] < exp_keys[j-1]; j--) begin
                tmp           = exp_keys[j];
                exp_keys[j]   = exp_keys[j-1];
                exp_keys[j-1] = tmp;
            end
        end
        seen     = '0;
        prev_key = '0;
        for (int pos = 0; pos < LANES; pos++) begin
            read_reg(addr_t'(`REG_RESULT_BASE + 4 * pos));
            key = rd_word[`KEY_MSB:0];
            tag = rd_word[`TAG_MSB:`TAG_LSB];
            assert (pos == 0 || key >= prev_key)
                else report_problem($sformatf("result keys decrease at position %0d", pos));
            assert (key == exp_keys[pos])
                else show_mismatch($sformatf("result[%0d] key", pos), exp_keys[pos], key);
            assert (tag < LANES && !seen[tag[TAG_W-1:0]])
                else report_problem($sformatf("origin tags are not a permutation at %0d", pos));
            seen[tag[TAG_W-1:0]] = 1'b1;
            assert (key == lane_model[tag[TAG_W-1:0]])
                else show_mismatch($sformatf("key of tag %0d", tag), lane_model[tag], key);
            prev_key = key;
        end
    endtask

    task automatic sort_and_check();
        launch_sort();
        sorts_done++;
        wait_for_count(sorts_done);
        check_results();
    endtask

    task automatic reset_state_reads_zero();
        read_reg(`REG_COUNT);
        assert (rd_word == '0) else show_mismatch("count", '0, rd_word);
        for (int pos = 0; pos < LANES; pos++) begin
            read_reg(addr_t'(`REG_RESULT_BASE + 4 * pos));
            assert (rd_word == '0)
                else show_mismatch($sformatf("result[%0d]", pos), '0, rd_word);
        end
    endtask

    task automatic sort_random_keys();
        for (int i = 0; i < LANES; i++) write_lane(i, key_t'($urandom()));
        sort_and_check();
    endtask

    task automatic sort_duplicates_and_extremes();
        key_t same;
        same = key_t'($urandom());
        for (int i = 0; i < LANES; i++) write_lane(i, same);
        sort_and_check();
        for (int i = 0; i < LANES; i++) begin
            write_lane(i, ((i ^ (i >> 2)) & 1) ? 16'hFFFF : 16'h0000);   // Extremes mixed
        end
        sort_and_check();
    endtask

    // One lane rewrite between launches keeps two vectors in flight
    task automatic pipelined_launches();
        int lane;
        for (int i = 0; i < LANES; i++) write_lane(i, key_t'($urandom()));
        launch_sort();
        for (int n = 0; n < 2; n++) begin
            lane = $urandom_range(LANES - 1, 0);
            write_lane(lane, ~lane_model[lane]);   // Differs from the previous vector
            launch_sort();
        end
        sorts_done += 3;
        wait_for_count(sorts_done);
        check_results();
    endtask

    task automatic read_at_fixed_latency();
        apb_data_t expected;
        expected = (apb_data_t'(LANES - 1) << `TAG_LSB) | apb_data_t'(16'hA500);
        for (int i = 0; i < LANES; i++) write_lane(i, key_t'(16'hA500 + (LANES - 1 - i)));
        read_reg(`REG_RESULT_BASE);
        assert (rd_word != expected) else report_problem("old result already equals new vector");
        launch_sort();
        repeat (STAGES) @(posedge xif);
        #1;
        read_reg(`REG_RESULT_BASE);   // Access at CTRL access + STAGES + 2
        assert (rd_word == expected) else show_mismatch("result[0] at latency", expected, rd_word);
        sorts_done++;
        wait_for_count(sorts_done);
        check_results();
    endtask

    task automatic bus_error_responses();
        write_reg(`REG_RESULT_BASE, 32'h0000_1234);
        assert (bus_err) else report_problem("write to a result address gave no slave error");
        read_reg(8'h20);
        assert (bus_err) else report_problem("read of an unmapped address gave no slave error");
        repeat (STAGES + 2) @(posedge xif);
        #1;
        read_reg(`REG_COUNT);
        assert (rd_word == apb_data_t'(sorts_done))
            else show_mismatch("count", apb_data_t'(sorts_done), rd_word);
    endtask

    ast_pready_high : assert property (@(posedge xif) disable iff (!rst_n) apb_rsp.pready)
        else report_problem("pready went low");

    ast_slverr_map : assert property (@(posedge xif) disable iff (!rst_n)
        apb_rsp.pslverr == slverr_expected(apb_req))
        else show_mismatch("pslverr", apb_data_t'(slverr_expected(apb_req)),
                           apb_data_t'(apb_rsp.pslverr));

    initial begin : watchdog
        #(NUM_TESTS * 200 * CLK_PERIOD);
        report_problem("timeout, the tests did not finish in time");
    end

    initial begin
        void'($urandom(SEED));
        xif        = 1'b0;
        rst_n      = 1'b0;
        apb_req    = '0;
        rd_word    = '0;
        bus_err    = 1'b0;
        sorts_done = '0;
        for (int i = 0; i < LANES; i++) lane_model[i] = '0;
        repeat (2) @(posedge xif);
        #1;
        rst_n = 1'b1;

        reset_state_reads_zero();
        sort_random_keys();
        sort_duplicates_and_extremes();
        pipelined_launches();
        read_at_fixed_latency();
        bus_error_responses();

        $display("Verification passed");
        $finish;
    end

endmodule

// File: sort_engine.f
+incdir+include
hdl/sort_pkg.sv
hdl/apb_lane_loader.sv
hdl/bitonic_sorter.sv
hdl/sort_result_store.sv
hdl/sort_engine.sv
verification/sort_engine_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the sort engine testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal \
    -f sort_engine.f --top-module sort_engine_tb -o sort_engine_sim \
    || { echo "Build failed"; exit 1; }

./obj_dir/sort_engine_sim 2>&1 | tee "$LOG"

grep -q "Verification failed" "$LOG" && { echo "Simulation FAILED"; exit 1; }
grep -q "Verification passed" "$LOG" && { echo "Simulation PASSED"; exit 0; }

echo "Simulation ended without a result"
exit 1
